/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ccd_timing
FILELIST  = ccd_timing.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ad_horizontal_driver.sv */
`timescale 1ns/10ps

module ad_horizontal_driver (
	input  logic clk,	// 8x pixel clock
	input  logic reset,
	input  logic i_hl_mask_pol,	// hl level while blanked
	input  logic i_h1_mask_pol,
	input  logic i_h2_mask_pol,
	input  logic i_hblk_n,	// low = blank
	output logic o_hl,
	output logic o_h1,
	output logic o_h2,
	output logic o_rg,	// reset gate runs opposite to hl
	output logic o_pix_start	// phase 0 strobe
);

	import ccd_timing_pkg::*;

	localparam int NUM_H = 3;	// hl, h1, h2

	logic [PHASE_W-1:0] phase;
	logic [NUM_H-1:0]   mask_pol;
	logic [NUM_H-1:0]   h_q;
	logic               rg_q;	// reset gate flop

	// ------------------------------
	// phase counter 0..7
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= '0;
		end else if (phase == PHASE_W'(PHASES_PER_PIXEL - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	assign o_pix_start = (phase == '0);	// rest of design aligns to this

	// ------------------------------
	// hl/h1/h2 share one rule
	// ------------------------------
	assign mask_pol = {i_h2_mask_pol, i_h1_mask_pol, i_hl_mask_pol};

	always_ff @(posedge clk) begin
		if (reset) begin
			h_q  <= '0;
			rg_q <= 1'b1;
		end else begin
			for (int i = 0; i < NUM_H; i++) begin
				if (!i_hblk_n) begin
					h_q[i] <= mask_pol[i];	// park at polarity while blanked
				end else if (phase == PHASE_LOW) begin
					h_q[i] <= 1'b0;
				end else if (phase == PHASE_HIGH) begin
					h_q[i] <= 1'b1;
				end
			end
			// rg takes the opposite level on the same edges
			if (!i_hblk_n) begin
				rg_q <= !mask_pol[0];
			end else if (phase == PHASE_LOW) begin
				rg_q <= 1'b1;
			end else if (phase == PHASE_HIGH) begin
				rg_q <= 1'b0;
			end
		end
	end

	assign o_hl = h_q[0];
	assign o_h1 = h_q[1];
	assign o_h2 = h_q[2];
	assign o_rg = rg_q;

endmodule

/* axil_timing_regs.sv */
`timescale 1ns/10ps

module axil_timing_regs #(
	parameter int PIX_W  = 12,
	parameter int LINE_W = 12
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  i_frame_start,	// shadow load strobe
	// write address / data, taken together
	input  logic [ccd_timing_pkg::AXI_ADDR_W-1:0] i_awaddr,
	input  logic                                  i_awvalid,
	output logic                                  o_awready,
	input  logic [ccd_timing_pkg::AXI_DATA_W-1:0] i_wdata,
	input  logic [ccd_timing_pkg::AXI_STRB_W-1:0] i_wstrb,
	input  logic                                  i_wvalid,
	output logic                                  o_wready,
	output logic [1:0]                            o_bresp,
	output logic                                  o_bvalid,
	input  logic                                  i_bready,
	// read channels
	input  logic [ccd_timing_pkg::AXI_ADDR_W-1:0] i_araddr,
	input  logic                                  i_arvalid,
	output logic                                  o_arready,
	output logic [ccd_timing_pkg::AXI_DATA_W-1:0] o_rdata,
	output logic [1:0]                            o_rresp,
	output logic                                  o_rvalid,
	input  logic                                  i_rready,
	timing_cfg_if.regs                            cfg
);

	import ccd_timing_pkg::*;

	logic [CTRL_W-1:0]      ctrl;	// enable + polarities, live
	logic [PIX_W-1:0]       line_pixels_sh;	// shadow geometry
	logic [PIX_W-1:0]       hblk_pixels_sh;
	logic [LINE_W-1:0]      frame_lines_sh;
	logic [LINE_W-1:0]      vblk_lines_sh;
	logic [FRAME_CNT_W-1:0] frame_cnt;
	logic                   wr_en;
	logic                   rd_en;

	// byte-lane merge of a write into the old value
	function automatic logic [AXI_DATA_W-1:0] merge_strb(
		input logic [AXI_DATA_W-1:0] old_val,
		input logic [AXI_DATA_W-1:0] new_val,
		input logic [AXI_STRB_W-1:0] strb
	);
		logic [AXI_DATA_W-1:0] res;
		res = old_val;
		for (int i = 0; i < AXI_STRB_W; i++) begin
			if (strb[i]) res[8*i +: 8] = new_val[8*i +: 8];
		end
		return res;
	endfunction

	// ------------------------------
	// handshakes
	// ------------------------------
	assign o_awready = i_wvalid && !o_bvalid;	// aw and w accepted as a pair
	assign o_wready  = i_awvalid && !o_bvalid;
	assign wr_en     = i_awvalid && i_wvalid && !o_bvalid;
	assign o_arready = !o_rvalid;	// held rdata blocks next read
	assign rd_en     = i_arvalid && o_arready;
	assign o_bresp   = RESP_OKAY;
	assign o_rresp   = RESP_OKAY;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end else begin
			if (wr_en) o_bvalid <= 1'b1;	// response one cycle later
			else if (i_bready) o_bvalid <= 1'b0;
			if (rd_en) o_rvalid <= 1'b1;
			else if (i_rready) o_rvalid <= 1'b0;
		end
	end

	// ------------------------------
	// register writes
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl           <= '0;	// disabled, all masks low
			line_pixels_sh <= PIX_W'(DEFAULT_LINE_PIXELS);
			hblk_pixels_sh <= PIX_W'(DEFAULT_HBLK_PIXELS);
			frame_lines_sh <= LINE_W'(DEFAULT_FRAME_LINES);
			vblk_lines_sh  <= LINE_W'(DEFAULT_VBLK_LINES);
		end else if (wr_en) begin
			case (i_awaddr)
				ADDR_CTRL:
					ctrl <= CTRL_W'(merge_strb(AXI_DATA_W'(ctrl), i_wdata, i_wstrb));
				ADDR_LINE_PIXELS:
					line_pixels_sh <= PIX_W'(merge_strb(AXI_DATA_W'(line_pixels_sh),
						i_wdata, i_wstrb));
				ADDR_HBLK_PIXELS:
					hblk_pixels_sh <= PIX_W'(merge_strb(AXI_DATA_W'(hblk_pixels_sh),
						i_wdata, i_wstrb));
				ADDR_FRAME_LINES:
					frame_lines_sh <= LINE_W'(merge_strb(AXI_DATA_W'(frame_lines_sh),
						i_wdata, i_wstrb));
				ADDR_VBLK_LINES:
					vblk_lines_sh <= LINE_W'(merge_strb(AXI_DATA_W'(vblk_lines_sh),
						i_wdata, i_wstrb));
				default: ;	// status and holes ignore writes
			endcase
		end
	end

	// shadow -> active only at frame start, frame never changes shape midway
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg.line_pixels <= PIX_W'(DEFAULT_LINE_PIXELS);
			cfg.hblk_pixels <= PIX_W'(DEFAULT_HBLK_PIXELS);
			cfg.frame_lines <= LINE_W'(DEFAULT_FRAME_LINES);
			cfg.vblk_lines  <= LINE_W'(DEFAULT_VBLK_LINES);
			frame_cnt       <= '0;
		end else if (i_frame_start) begin
			cfg.line_pixels <= line_pixels_sh;
			cfg.hblk_pixels <= hblk_pixels_sh;
			cfg.frame_lines <= frame_lines_sh;
			cfg.vblk_lines  <= vblk_lines_sh;
			frame_cnt       <= frame_cnt + 1'b1;	// wraps at 16 bits
		end
	end

	// control bits bypass the shadow
	assign cfg.enable = ctrl[CTRL_ENABLE_BIT];
	assign cfg.hl_pol = ctrl[CTRL_HL_POL_BIT];
	assign cfg.h1_pol = ctrl[CTRL_H1_POL_BIT];
	assign cfg.h2_pol = ctrl[CTRL_H2_POL_BIT];

	// ------------------------------
	// read mux, registered
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rd_en) begin
			case (i_araddr)
				ADDR_CTRL:        o_rdata <= AXI_DATA_W'(ctrl);
				ADDR_LINE_PIXELS: o_rdata <= AXI_DATA_W'(line_pixels_sh);	// shadow value
				ADDR_HBLK_PIXELS: o_rdata <= AXI_DATA_W'(hblk_pixels_sh);
				ADDR_FRAME_LINES: o_rdata <= AXI_DATA_W'(frame_lines_sh);
				ADDR_VBLK_LINES:  o_rdata <= AXI_DATA_W'(vblk_lines_sh);
				ADDR_STATUS:      o_rdata <= AXI_DATA_W'(frame_cnt);
				default:          o_rdata <= '0;
			endcase
		end
	end

endmodule

/* ccd_timing.f */
ccd_timing_pkg.sv
timing_cfg_if.sv
axil_timing_regs.sv
line_frame_timing.sv
ad_horizontal_driver.sv
vertical_transfer_driver.sv
ccd_timing_top.sv
ccd_timing_assertions.sv
tb_ccd_timing.sv

/* ccd_timing_assertions.sv */
`timescale 1ns/10ps

module ccd_timing_assertions #(
	parameter bit CHECK_HDRV = 1'b1	// 1: h driver rules, 0: line timing rules
) (
	input logic clk,
	input logic reset,
	input logic i_hl,
	input logic i_rg,
	input logic i_pix_start,
	input logic i_hblk_n,
	input logic i_enable
);

	import ccd_timing_pkg::*;

	int gap;	// clocks since last pix_start
	bit seen;	// first pix_start passed

	always_ff @(posedge clk) begin
		if (reset) begin
			gap  <= 0;
			seen <= 1'b0;
		end else if (i_pix_start) begin
			gap  <= 1;
			seen <= 1'b1;
		end else begin
			gap <= gap + 1;
		end
	end

	if (CHECK_HDRV) begin : g_hdrv
		rg_inverse: assert property (@(posedge clk) disable iff (reset) i_rg == !i_hl)
			else $error("rg is not the inverse of hl");
		// strobe exactly once per pixel period
		pix_period: assert property (@(posedge clk) disable iff (reset)
			seen |-> (i_pix_start == (gap == PHASES_PER_PIXEL)))
			else $error("pix_start not spaced by one pixel period");
	end else begin : g_timing
		blank_when_off: assert property (@(posedge clk) disable iff (reset)
			!i_enable |=> !i_hblk_n)
			else $error("hblk_n high while timing disabled");
	end

endmodule

bind ad_horizontal_driver ccd_timing_assertions #(.CHECK_HDRV(1'b1)) u_assertions (
	.clk(clk), .reset(reset), .i_hl(o_hl), .i_rg(o_rg), .i_pix_start(o_pix_start),
	.i_hblk_n(i_hblk_n), .i_enable(1'b1)
);

bind line_frame_timing ccd_timing_assertions #(.CHECK_HDRV(1'b0)) u_assertions (
	.clk(clk), .reset(reset), .i_hl(1'b0), .i_rg(1'b1), .i_pix_start(i_pix_start),
	.i_hblk_n(o_hblk_n), .i_enable(cfg.enable)
);

/* ccd_timing_pkg.sv */
package ccd_timing_pkg;

	// ------------------------------
	// horizontal pixel timing
	// ------------------------------
	localparam int PHASES_PER_PIXEL = 8;	// sys clocks per pixel
	localparam int PHASE_W = $clog2(PHASES_PER_PIXEL);
	localparam logic [PHASE_W-1:0] PHASE_LOW  = 3'd1;	// hl/h1/h2 fall here
	localparam logic [PHASE_W-1:0] PHASE_HIGH = 3'd5;	// and rise here

	// ------------------------------
	// vertical timing
	// ------------------------------
	localparam int V_PHASES      = 4;	// four-phase vertical transfer
	localparam int V_STEP_PIXELS = 1;	// pixels per v step
	localparam int XSG_PIXELS    = 4;	// sensor gate width

	// ------------------------------
	// axi4-lite register map
	// ------------------------------
	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL        = 8'h00;
	localparam logic [AXI_ADDR_W-1:0] ADDR_LINE_PIXELS = 8'h04;
	localparam logic [AXI_ADDR_W-1:0] ADDR_HBLK_PIXELS = 8'h08;
	localparam logic [AXI_ADDR_W-1:0] ADDR_FRAME_LINES = 8'h0C;
	localparam logic [AXI_ADDR_W-1:0] ADDR_VBLK_LINES  = 8'h10;
	localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS      = 8'h14;	// frame counter, ro

	// control register bits
	localparam int CTRL_W          = 4;
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_HL_POL_BIT = 1;
	localparam int CTRL_H1_POL_BIT = 2;
	localparam int CTRL_H2_POL_BIT = 3;

	localparam int FRAME_CNT_W = 16;

	// geometry after reset
	localparam int DEFAULT_LINE_PIXELS = 64;
	localparam int DEFAULT_HBLK_PIXELS = 16;
	localparam int DEFAULT_FRAME_LINES = 16;
	localparam int DEFAULT_VBLK_LINES  = 2;

endpackage

/* ccd_timing_top.sv */
`timescale 1ns/10ps

module ccd_timing_top #(
	parameter int PIX_W  = 12,
	parameter int LINE_W = 12
) (
	input  logic                                  clk,
	input  logic                                  reset,
	// axi4-lite slave
	input  logic [ccd_timing_pkg::AXI_ADDR_W-1:0] i_awaddr,
	input  logic                                  i_awvalid,
	output logic                                  o_awready,
	input  logic [ccd_timing_pkg::AXI_DATA_W-1:0] i_wdata,
	input  logic [ccd_timing_pkg::AXI_STRB_W-1:0] i_wstrb,
	input  logic                                  i_wvalid,
	output logic                                  o_wready,
	output logic [1:0]                            o_bresp,
	output logic                                  o_bvalid,
	input  logic                                  i_bready,
	input  logic [ccd_timing_pkg::AXI_ADDR_W-1:0] i_araddr,
	input  logic                                  i_arvalid,
	output logic                                  o_arready,
	output logic [ccd_timing_pkg::AXI_DATA_W-1:0] o_rdata,
	output logic [1:0]                            o_rresp,
	output logic                                  o_rvalid,
	input  logic                                  i_rready,
	// ccd afe clocks
	output logic                                  o_hl,
	output logic                                  o_h1,
	output logic                                  o_h2,
	output logic                                  o_rg,
	output logic [ccd_timing_pkg::V_PHASES-1:0]   o_v,
	output logic                                  o_xsg,
	output logic                                  o_hd,
	output logic                                  o_vd
);

	logic pix_start;
	logic hblk_n;
	logic vblk;
	logic line_start;
	logic frame_start;

	timing_cfg_if #(.PIX_W(PIX_W), .LINE_W(LINE_W)) cfg_if ();

	// ------------------------------
	// registers
	// ------------------------------
	axil_timing_regs #(.PIX_W(PIX_W), .LINE_W(LINE_W)) u_regs (
		.clk(clk), .reset(reset), .i_frame_start(frame_start),
		.i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
		.i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
		.o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
		.i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
		.o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
		.cfg(cfg_if.regs)
	);

	// ------------------------------
	// timing and drivers
	// ------------------------------
	line_frame_timing #(.PIX_W(PIX_W), .LINE_W(LINE_W)) u_line_frame (
		.clk(clk), .reset(reset), .i_pix_start(pix_start), .cfg(cfg_if.timing),
		.o_hblk_n(hblk_n), .o_vblk(vblk), .o_line_start(line_start),
		.o_frame_start(frame_start), .o_hd(o_hd), .o_vd(o_vd)
	);

	ad_horizontal_driver u_hdrv (
		.clk(clk), .reset(reset),
		.i_hl_mask_pol(cfg_if.hl_pol), .i_h1_mask_pol(cfg_if.h1_pol),
		.i_h2_mask_pol(cfg_if.h2_pol), .i_hblk_n(hblk_n),
		.o_hl(o_hl), .o_h1(o_h1), .o_h2(o_h2), .o_rg(o_rg), .o_pix_start(pix_start)
	);

	vertical_transfer_driver u_vdrv (
		.clk(clk), .reset(reset), .i_pix_start(pix_start),
		.i_line_start(line_start), .i_frame_start(frame_start), .i_vblk(vblk),
		.o_v(o_v), .o_xsg(o_xsg)
	);

endmodule

/* line_frame_timing.sv */
`timescale 1ns/10ps

module line_frame_timing #(
	parameter int PIX_W  = 12,
	parameter int LINE_W = 12
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_pix_start,	// phase-0 strobe from h driver
	timing_cfg_if.timing cfg,
	output logic       o_hblk_n,	// combined mask, low = blank
	output logic       o_vblk,
	output logic       o_line_start,	// first cycle of pixel 0
	output logic       o_frame_start,	// first cycle of pixel 0, line 0
	output logic       o_hd,	// low for pixel 0
	output logic       o_vd	// low for line 0
);

	logic              running;	// set by first pix_start after reset
	logic [PIX_W-1:0]  pix_cnt;
	logic [LINE_W-1:0] line_cnt;
	logic              pix_wrap;
	logic              line_wrap;
	logic [PIX_W-1:0]  pix_d;
	logic [LINE_W-1:0] line_d;

	// ------------------------------
	// next counter values
	// ------------------------------
	// first strobe after reset lands on pixel 0 of line 0
	assign pix_wrap  = !running || (pix_cnt >= cfg.line_pixels - 1'b1);
	assign line_wrap = !running || (line_cnt >= cfg.frame_lines - 1'b1);

	always_comb begin
		pix_d  = pix_cnt;
		line_d = line_cnt;
		if (i_pix_start) begin
			if (pix_wrap) begin
				pix_d  = '0;
				line_d = line_wrap ? '0 : line_cnt + 1'b1;
			end else begin
				pix_d = pix_cnt + 1'b1;
			end
		end
	end

	// ------------------------------
	// counters, mask and syncs
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			running       <= 1'b0;
			pix_cnt       <= '0;
			line_cnt      <= '0;
			o_hblk_n      <= 1'b0;
			o_vblk        <= 1'b0;
			o_hd          <= 1'b1;
			o_vd          <= 1'b1;
			o_line_start  <= 1'b0;
			o_frame_start <= 1'b0;
		end else begin
			running  <= running || i_pix_start;
			pix_cnt  <= pix_d;
			line_cnt <= line_d;
			// mask re-evaluated every clock so enable=0 blanks at once
			o_hblk_n <= cfg.enable && (pix_d >= cfg.hblk_pixels) &&
				(line_d >= cfg.vblk_lines);
			o_vblk   <= line_d < cfg.vblk_lines;
			o_hd     <= pix_d != '0;
			o_vd     <= line_d != '0;
			o_line_start  <= i_pix_start && pix_wrap;	// one-clock pulses
			o_frame_start <= i_pix_start && pix_wrap && line_wrap;
		end
	end

endmodule

/* tb_ccd_timing.sv */
`timescale 1ns/10ps

module tb_ccd_timing;

	import ccd_timing_pkg::*;

	localparam int PIX_W         = 12;
	localparam int LINE_W        = 12;
	localparam int AXI_TIMEOUT   = 200;	// clocks per handshake wait
	localparam int FRAME_TIMEOUT = 20000;	// default frame is 8192 clocks

	logic                  clk = 1'b0;
	logic                  reset;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_STRB_W-1:0] wstrb;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [AXI_DATA_W-1:0] rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;
	logic                  hl;
	logic                  h1;
	logic                  h2;
	logic                  rg;
	logic                  xsg;
	logic                  hd;
	logic                  vd;
	logic [V_PHASES-1:0]   v;

	logic [31:0] lcg_state;
	int          errors;
	int          checks;
	bit          aborted;	// a wait ran out of time
	string       test_name;

	// register model updated at the accepting edge
	logic [CTRL_W-1:0] m_ctrl;
	int m_sh_line;	// shadows
	int m_sh_hblk;
	int m_sh_frame;
	int m_sh_vblk;
	int m_line;	// active geometry
	int m_hblk;
	int m_frame;
	int m_vblk;

	// timing model
	int         cyc;	// clocks since reset
	bit         seen_reset;
	bit         started;
	int         mp;	// pixel index
	int         ml;	// line index
	bit         m_hblk_n;
	bit         m_active;	// current line gets v transfer
	bit         load_pending;
	logic [2:0] m_h;	// {h2, h1, hl}

	ccd_timing_top #(.PIX_W(PIX_W), .LINE_W(LINE_W)) uut (
		.clk(clk), .reset(reset),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
		.i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
		.o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
		.i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
		.o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
		.o_hl(hl), .o_h1(h1), .o_h2(h2), .o_rg(rg), .o_v(v), .o_xsg(xsg),
		.o_hd(hd), .o_vd(vd)
	);

	always #4 clk = ~clk;	// 8 ns

	function automatic int rand_below(input int n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[23:8]) % n;
	endfunction

	// ------------------------------
	// reference model
	// ------------------------------
	// c counts clocks before this edge so phase is c mod 8
	function automatic logic [2:0] next_hclk(input int c, input logic [2:0] h,
		input bit hblk_n, input logic [2:0] pol);
		if (!hblk_n) return pol;	// blanked
		if (c % PHASES_PER_PIXEL == 1) return 3'b000;
		if (c % PHASES_PER_PIXEL == 5) return 3'b111;
		return h;
	endfunction

	// {hl, h1, h2, rg, hd, vd, v, xsg}
	function automatic logic [10:0] expect_outputs(input bit run, input int p, input int l,
		input bit line_act, input logic [2:0] h);
		logic [3:0] ev;
		logic       ehd;
		logic       evd;
		logic       exsg;
		ev   = '0;
		ehd  = 1'b1;
		evd  = 1'b1;
		exsg = 1'b1;
		if (run) begin
			ehd = (p != 0);
			evd = (l != 0);
			if (line_act && p >= 1 && p <= V_PHASES) ev = 4'(1 << (p - 1));	// one pixel each
			if (l == 0 && p >= 1 && p <= XSG_PIXELS) exsg = 1'b0;
		end
		return {h[0], h[1], h[2], !h[0], ehd, evd, ev, exsg};
	endfunction

	task automatic step_model();
		bit pix_edge;
		if (reset) begin
			seen_reset   = 1'b1;
			cyc          = 0;
			started      = 1'b0;
			mp           = 0;
			ml           = 0;
			m_hblk_n     = 1'b0;
			m_active     = 1'b0;
			load_pending = 1'b0;
			m_h          = '0;
			m_line       = DEFAULT_LINE_PIXELS;
			m_hblk       = DEFAULT_HBLK_PIXELS;
			m_frame      = DEFAULT_FRAME_LINES;
			m_vblk       = DEFAULT_VBLK_LINES;
		end else begin
			pix_edge = (cyc % PHASES_PER_PIXEL == 0);
			m_h = next_hclk(cyc, m_h, m_hblk_n, m_ctrl[3:1]);
			if (pix_edge) begin
				if (!started || mp + 1 >= m_line) begin
					ml = (!started || ml + 1 >= m_frame) ? 0 : ml + 1;
					mp = 0;
				end else begin
					mp++;
				end
				started = 1'b1;
				if (mp == 0) m_active = (ml >= m_vblk);	// decided at line start
			end
			m_hblk_n = m_ctrl[0] && mp >= m_hblk && ml >= m_vblk;
			if (load_pending) begin	// edge after frame start
				m_line  = m_sh_line;
				m_hblk  = m_sh_hblk;
				m_frame = m_sh_frame;
				m_vblk  = m_sh_vblk;
			end
			load_pending = pix_edge && mp == 0 && ml == 0;
			cyc++;
		end
	endtask

	task automatic compare_outputs();
		logic [10:0] exp_o;
		logic [10:0] act_o;
		exp_o = expect_outputs(started, mp, ml, m_active, m_h);
		act_o = {hl, h1, h2, rg, hd, vd, v, xsg};
		checks++;
		if (act_o !== exp_o) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h at clock %0d", test_name, exp_o,
				act_o, cyc);
		end
	endtask

	// compare process samples outputs mid-cycle
	always begin
		@(posedge clk);
		step_model();
		@(negedge clk);
		if (seen_reset) compare_outputs();
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		errors++;
		aborted = 1'b1;
		$display("timeout in %s: %s", test_name, what);
	endtask

	task automatic check_value(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (!aborted) begin
			checks++;
			if (exp_val !== act_val) begin
				errors++;
				$display("mismatch %s %s: expected %h, actual %h", test_name, what, exp_val,
					act_val);
			end
		end
	endtask

	task automatic update_model_regs(input logic [AXI_ADDR_W-1:0] addr,
		input logic [AXI_DATA_W-1:0] data);
		case (addr)
			ADDR_CTRL:        m_ctrl     <= data[CTRL_W-1:0];
			ADDR_LINE_PIXELS: m_sh_line  <= int'(data[PIX_W-1:0]);
			ADDR_HBLK_PIXELS: m_sh_hblk  <= int'(data[PIX_W-1:0]);
			ADDR_FRAME_LINES: m_sh_frame <= int'(data[LINE_W-1:0]);
			ADDR_VBLK_LINES:  m_sh_vblk  <= int'(data[LINE_W-1:0]);
			default: ;
		endcase
	endtask

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
		input logic [AXI_DATA_W-1:0] data);
		int t;
		if (!aborted) begin
			@(posedge clk);
			awaddr  <= addr;
			wdata   <= data;
			wstrb   <= '1;
			awvalid <= 1'b1;
			wvalid  <= 1'b1;
			t = 0;
			do begin
				@(negedge clk);
				t++;
			end while (!(awready && wready) && t < AXI_TIMEOUT);
			if (!(awready && wready)) begin
				fail_timeout("write address and data not accepted");
			end else begin
				@(posedge clk);	// accepting edge
				awvalid <= 1'b0;
				wvalid  <= 1'b0;
				update_model_regs(addr, data);
				t = 0;
				do begin
					@(negedge clk);
					t++;
				end while (!bvalid && t < AXI_TIMEOUT);
				if (!bvalid) begin
					fail_timeout("no write response");
				end else begin
					check_value("bresp", 32'h0, 32'(bresp));	// okay
					@(posedge clk);	// bready held high
				end
			end
		end
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
		output logic [AXI_DATA_W-1:0] data);
		int t;
		data = '0;
		if (!aborted) begin
			@(posedge clk);
			araddr  <= addr;
			arvalid <= 1'b1;
			t = 0;
			do begin
				@(negedge clk);
				t++;
			end while (!arready && t < AXI_TIMEOUT);
			if (!arready) begin
				fail_timeout("read address not accepted");
			end else begin
				@(posedge clk);
				arvalid <= 1'b0;
				t = 0;
				do begin
					@(negedge clk);
					t++;
				end while (!rvalid && t < AXI_TIMEOUT);
				if (!rvalid) begin
					fail_timeout("no read data");
				end else begin
					data = rdata;
					check_value("rresp", 32'h0, 32'(rresp));	// okay
					@(posedge clk);
				end
			end
		end
	endtask

	// returns on the negedge after vd falls
	task automatic wait_frame_start();
		int   t;
		logic prev;
		bit   found;
		t     = 0;
		found = 1'b0;
		if (!aborted) begin
			prev = vd;
			do begin
				@(negedge clk);
				if (prev && !vd) found = 1'b1;
				prev = vd;
				t++;
			end while (!found && t < FRAME_TIMEOUT);
			if (!found) fail_timeout("vd never fell");
		end
	endtask

	// clocks between two hd falls
	task automatic measure_hd_period(output int clocks);
		int   t;
		int   falls;
		logic prev;
		t      = 0;
		falls  = 0;
		clocks = 0;
		if (!aborted) begin
			prev = hd;
			do begin
				@(negedge clk);
				if (falls == 1) clocks++;
				if (prev && !hd) falls++;
				prev = hd;
				t++;
			end while (falls < 2 && t < FRAME_TIMEOUT);
			if (falls < 2) fail_timeout("hd stopped pulsing");
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		logic [2:0]            pol;
		logic [AXI_DATA_W-1:0] rd;
		logic [AXI_DATA_W-1:0] status_0;
		int lp;
		int hb;
		int fl;
		int vb;
		int period;
		reset      = 1'b1;
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		wvalid     = 1'b0;
		bready     = 1'b1;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b1;
		lcg_state  = 32'h4993_39d6;
		errors     = 0;
		checks     = 0;
		aborted    = 1'b0;
		test_name  = "reset";
		m_ctrl     = '0;
		m_sh_line  = DEFAULT_LINE_PIXELS;
		m_sh_hblk  = DEFAULT_HBLK_PIXELS;
		m_sh_frame = DEFAULT_FRAME_LINES;
		m_sh_vblk  = DEFAULT_VBLK_LINES;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		test_name = "mask_disabled";	// clocks parked at polarity while enable is low
		for (int i = 0; i < 6; i++) begin
			pol = 3'(rand_below(8));
			axi_write(ADDR_CTRL, AXI_DATA_W'({pol, 1'b0}));
		end

		test_name = "reg_access";
		lp = 10 + rand_below(8);
		hb = 1 + rand_below(3);
		fl = 5 + rand_below(4);
		vb = 1 + rand_below(2);
		axi_write(ADDR_LINE_PIXELS, AXI_DATA_W'(lp));
		axi_write(ADDR_HBLK_PIXELS, AXI_DATA_W'(hb));
		axi_write(ADDR_FRAME_LINES, AXI_DATA_W'(fl));
		axi_write(ADDR_VBLK_LINES, AXI_DATA_W'(vb));
		axi_read(ADDR_CTRL, rd);
		check_value("ctrl", AXI_DATA_W'(m_ctrl), rd);
		axi_read(ADDR_LINE_PIXELS, rd);
		check_value("line_pixels", AXI_DATA_W'(lp), rd);
		axi_read(ADDR_HBLK_PIXELS, rd);
		check_value("hblk_pixels", AXI_DATA_W'(hb), rd);
		axi_read(ADDR_FRAME_LINES, rd);
		check_value("frame_lines", AXI_DATA_W'(fl), rd);
		axi_read(ADDR_VBLK_LINES, rd);
		check_value("vblk_lines", AXI_DATA_W'(vb), rd);
		axi_read(ADDR_STATUS, status_0);

		test_name = "active_clocks";
		pol = 3'(rand_below(8));
		axi_write(ADDR_CTRL, AXI_DATA_W'({pol, 1'b1}));
		wait_frame_start();	// new geometry from here
		wait_frame_start();

		test_name = "line_geometry";
		measure_hd_period(period);
		check_value("hd period", AXI_DATA_W'(lp * PHASES_PER_PIXEL), AXI_DATA_W'(period));

		test_name = "shadow_geometry";
		wait_frame_start();
		axi_write(ADDR_LINE_PIXELS, AXI_DATA_W'(lp + 3));	// mid-frame
		measure_hd_period(period);
		check_value("old hd period", AXI_DATA_W'(lp * PHASES_PER_PIXEL), AXI_DATA_W'(period));
		wait_frame_start();
		measure_hd_period(period);
		check_value("new hd period", AXI_DATA_W'((lp + 3) * PHASES_PER_PIXEL),
			AXI_DATA_W'(period));

		test_name = "vertical_transfer";
		wait_frame_start();
		wait_frame_start();

		test_name = "frame_counter";	// several frames passed since the first read
		axi_read(ADDR_STATUS, rd);
		if (!aborted) begin
			checks++;
			if (rd <= status_0) begin
				errors++;
				$display("frame counter did not advance in %s: %0d before, %0d after",
					test_name, status_0, rd);
			end
		end
		finish_run();
	end

endmodule

/* timing_cfg_if.sv */
`timescale 1ns/10ps

// active timing config, register file -> timing blocks
interface timing_cfg_if #(
	parameter int PIX_W  = 12,
	parameter int LINE_W = 12
) ();

	logic              enable;	// timing run
	logic              hl_pol;	// hl level while masked
	logic              h1_pol;
	logic              h2_pol;
	logic [PIX_W-1:0]  line_pixels;	// pixels per line, incl blank
	logic [PIX_W-1:0]  hblk_pixels;	// masked pixels at line start
	logic [LINE_W-1:0] frame_lines;	// lines per frame, incl blank
	logic [LINE_W-1:0] vblk_lines;	// blank lines at frame start

	modport regs (
		output enable, hl_pol, h1_pol, h2_pol,
		output line_pixels, hblk_pixels, frame_lines, vblk_lines
	);

	modport timing (
		input enable, hl_pol, h1_pol, h2_pol,
		input line_pixels, hblk_pixels, frame_lines, vblk_lines
	);

endinterface

/* vertical_transfer_driver.sv */
`timescale 1ns/10ps

module vertical_transfer_driver (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                i_pix_start,	// pixel boundary strobe
	input  logic                                i_line_start,
	input  logic                                i_frame_start,
	input  logic                                i_vblk,	// valid with line_start
	output logic [ccd_timing_pkg::V_PHASES-1:0] o_v,	// one-hot v1..v4
	output logic                                o_xsg	// sensor gate, low active
);

	import ccd_timing_pkg::*;

	localparam int STEP_W = $clog2(V_STEP_PIXELS + 1);
	localparam int IDX_W  = $clog2(V_PHASES);
	localparam int XSG_W  = $clog2(XSG_PIXELS + 1);

	typedef enum logic [1:0] {
		V_IDLE,	// waiting for an active line
		V_WAIT,	// armed, start on next pixel boundary
		V_RUN	// stepping v phases
	} v_state_t;

	v_state_t          v_state;
	logic [IDX_W-1:0]  v_idx;	// current v phase
	logic [STEP_W-1:0] step_pix;	// pixels spent in phase
	logic              xsg_wait;
	logic [XSG_W-1:0]  xsg_cnt;	// pixels of gate left

	// ------------------------------
	// vertical transfer fsm
	// ------------------------------
	// line_start sits in pixel 0, so the first step begins on pixel 1
	always_ff @(posedge clk) begin
		if (reset) begin
			v_state  <= V_IDLE;
			v_idx    <= '0;
			step_pix <= '0;
		end else begin
			case (v_state)
				V_IDLE: if (i_line_start && !i_vblk) v_state <= V_WAIT;
				V_WAIT: if (i_pix_start) begin
					v_state  <= V_RUN;
					v_idx    <= '0;
					step_pix <= '0;
				end
				V_RUN: if (i_pix_start) begin
					if (step_pix == STEP_W'(V_STEP_PIXELS - 1)) begin
						step_pix <= '0;
						if (v_idx == IDX_W'(V_PHASES - 1)) v_state <= V_IDLE;	// back to 0
						else v_idx <= v_idx + 1'b1;
					end else begin
						step_pix <= step_pix + 1'b1;
					end
				end
				default: v_state <= V_IDLE;
			endcase
		end
	end

	assign o_v = (v_state == V_RUN) ? (V_PHASES'(1) << v_idx) : '0;

	// ------------------------------
	// xsg pulse, once per frame
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			xsg_wait <= 1'b0;
			xsg_cnt  <= '0;
		end else begin
			if (i_frame_start) xsg_wait <= 1'b1;
			if (i_pix_start) begin
				if (xsg_wait) begin
					xsg_wait <= 1'b0;
					xsg_cnt  <= XSG_W'(XSG_PIXELS);	// pixel aligned start
				end else if (xsg_cnt != '0) begin
					xsg_cnt <= xsg_cnt - 1'b1;
				end
			end
		end
	end

	assign o_xsg = (xsg_cnt == '0);	// idle high

endmodule
